// File: Bender.yml
package:
  name: rob

sources:
  - design/rob_pkg.sv
  - design/tag_router.sv
  - design/thread_rob.sv
  - design/commit_select.sv
  - design/rob_top.sv
  - target: test
    files:
      - verification/rob_tb.sv

// File: design/commit_select.sv
// two-wide commit selector
`timescale 1ns/1ps
`default_nettype none

module commit_select import rob_pkg::*; (
	input rob_entry_t entries_t1 [2],
	input rob_entry_t entries_t2 [2],
	input ptr_t occupancy_t1,
	input ptr_t occupancy_t2,
	output commit_slot_t commit_slots [2],
	output logic [1:0] retire_t1,
	output logic [1:0] retire_t2,
	output logic flush_t1,
	output logic flush_t2
);

	logic [1:0] elig_t1;	// head and head plus one ready to retire
	logic [1:0] elig_t2;
	logic [1:0] sel_valid;
	logic [1:0] sel_t1;
	logic [1:0] sel_offset;	// 1 picks the entry behind the head

	function automatic commit_slot_t to_commit(input rob_entry_t entry, input logic thread1);
		commit_slot_t slot;
		slot.valid = 1'b1;
		slot.is_thread1 = thread1;
		slot.pc = entry.slot.pc;
		slot.target_pc = entry.target_pc;
		slot.is_branch = entry.slot.is_branch;
		slot.mispredict = entry.mispredict;
		slot.arn = entry.slot.arn;
		slot.prn = entry.slot.prn;
		return slot;
	endfunction

	assign elig_t1[0] = occupancy_t1 != '0 && entries_t1[0].executed;
	assign elig_t1[1] = occupancy_t1 >= ptr_t'(2) && entries_t1[1].executed;
	assign elig_t2[0] = occupancy_t2 != '0 && entries_t2[0].executed;
	assign elig_t2[1] = occupancy_t2 >= ptr_t'(2) && entries_t2[1].executed;

	always_comb
	begin
		rob_entry_t first;
		logic first_flush;
		logic same_next;
		logic other_head;
		sel_valid = '0;
		sel_t1 = '0;
		sel_offset = '0;
		// thread 1 has first claim
		if (elig_t1[0])
		begin
			sel_valid[0] = 1'b1;
			sel_t1[0] = 1'b1;
		end
		else if (elig_t2[0])
			sel_valid[0] = 1'b1;
		first = sel_t1[0] ? entries_t1[0] : entries_t2[0];
		first_flush = first.slot.is_branch && first.mispredict;
		same_next = sel_t1[0] ? elig_t1[1] : elig_t2[1];
		other_head = sel_t1[0] ? elig_t2[0] : elig_t1[0];
		if (sel_valid[0])
		begin
			if (!first_flush && same_next)
			begin
				sel_valid[1] = 1'b1;
				sel_t1[1] = sel_t1[0];
				sel_offset[1] = 1'b1;
			end
			else if (other_head)
			begin
				sel_valid[1] = 1'b1;
				sel_t1[1] = !sel_t1[0];
			end
		end
	end

	always_comb
	begin
		rob_entry_t chosen;
		retire_t1 = '0;
		retire_t2 = '0;
		flush_t1 = 1'b0;
		flush_t2 = 1'b0;
		for (int k = 0; k < 2; k++)
		begin
			chosen = sel_t1[k] ? entries_t1[sel_offset[k]] : entries_t2[sel_offset[k]];
			commit_slots[k] = '0;
			if (sel_valid[k])
			begin
				commit_slots[k] = to_commit(chosen, sel_t1[k]);
				if (sel_t1[k])
				begin
					retire_t1 = retire_t1 + 2'd1;
					flush_t1 = flush_t1 || (chosen.slot.is_branch && chosen.mispredict);
				end
				else
				begin
					retire_t2 = retire_t2 + 2'd1;
					flush_t2 = flush_t2 || (chosen.slot.is_branch && chosen.mispredict);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/rob_pkg.sv
// reorder buffer types
`default_nettype none

package rob_pkg;

	localparam int rob_depth = 16;	// entries per thread
	localparam int index_width = $clog2(rob_depth);
	localparam int xlen = 64;
	localparam int arn_width = 5;
	localparam int prn_width = 6;

	typedef logic [index_width-1:0] index_t;
	typedef logic [index_width:0] ptr_t;	// wrap bit above the index

	// thread bit low selects thread 1
	typedef struct packed {
		logic is_thread2;
		index_t index;
	} rob_tag_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [arn_width-1:0] arn;
		logic [prn_width-1:0] prn;
		logic is_branch;
	} dispatch_slot_t;

	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		logic mispredict;
		logic [xlen-1:0] target_pc;
	} completion_t;

	typedef struct packed {
		dispatch_slot_t slot;
		logic executed;
		logic mispredict;	// resolved branch went the other way
		logic [xlen-1:0] target_pc;
	} rob_entry_t;

	typedef struct packed {
		logic valid;
		logic is_thread1;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] target_pc;
		logic is_branch;
		logic mispredict;
		logic [arn_width-1:0] arn;
		logic [prn_width-1:0] prn;
	} commit_slot_t;

endpackage

`default_nettype wire

// File: design/rob_top.sv
// two-thread reorder buffer
`timescale 1ns/1ps
`default_nettype none

module rob_top import rob_pkg::*; (
	input logic clock,
	input logic reset,
	input logic dispatch_valid,
	input logic dispatch_thread1,
	input dispatch_slot_t dispatch_slots [2],
	output logic dispatch_ready,
	output rob_tag_t dispatch_tags [2],
	input completion_t completions [2],
	output commit_slot_t commit_slots [2]
);

	logic space_t1;
	logic space_t2;
	index_t tail_t1;
	index_t tail_t2;
	logic alloc_t1;
	logic alloc_t2;
	logic flush_t1;
	logic flush_t2;
	logic [1:0] retire_t1;
	logic [1:0] retire_t2;
	ptr_t occupancy_t1;
	ptr_t occupancy_t2;
	dispatch_slot_t alloc_slots [2];	// shared by both queues, alloc picks one
	completion_t mark_t1 [2];
	completion_t mark_t2 [2];
	rob_entry_t entries_t1 [2];
	rob_entry_t entries_t2 [2];

	tag_router router (
		.dispatch_valid(dispatch_valid),
		.dispatch_thread1(dispatch_thread1),
		.dispatch_slots(dispatch_slots),
		.dispatch_ready(dispatch_ready),
		.dispatch_tags(dispatch_tags),
		.completions(completions),
		.space_t1(space_t1),
		.space_t2(space_t2),
		.tail_t1(tail_t1),
		.tail_t2(tail_t2),
		.flush_t1(flush_t1),
		.flush_t2(flush_t2),
		.alloc_t1(alloc_t1),
		.alloc_t2(alloc_t2),
		.alloc_slots(alloc_slots),
		.mark_t1(mark_t1),
		.mark_t2(mark_t2)
	);

	thread_rob rob_t1 (
		.clock(clock),
		.reset(reset),
		.alloc(alloc_t1),
		.alloc_slots(alloc_slots),
		.marks(mark_t1),
		.retire_count(retire_t1),
		.flush(flush_t1),
		.has_space(space_t1),
		.tail_index(tail_t1),
		.head_entries(entries_t1),
		.occupancy(occupancy_t1)
	);

	thread_rob rob_t2 (
		.clock(clock),
		.reset(reset),
		.alloc(alloc_t2),
		.alloc_slots(alloc_slots),
		.marks(mark_t2),
		.retire_count(retire_t2),
		.flush(flush_t2),
		.has_space(space_t2),
		.tail_index(tail_t2),
		.head_entries(entries_t2),
		.occupancy(occupancy_t2)
	);

	commit_select selector (
		.entries_t1(entries_t1),
		.entries_t2(entries_t2),
		.occupancy_t1(occupancy_t1),
		.occupancy_t2(occupancy_t2),
		.commit_slots(commit_slots),
		.retire_t1(retire_t1),
		.retire_t2(retire_t2),
		.flush_t1(flush_t1),
		.flush_t2(flush_t2)
	);

endmodule

`default_nettype wire

// File: design/tag_router.sv
// dispatch and completion router
`timescale 1ns/1ps
`default_nettype none

module tag_router import rob_pkg::*; (
	input logic dispatch_valid,
	input logic dispatch_thread1,
	input dispatch_slot_t dispatch_slots [2],
	output logic dispatch_ready,
	output rob_tag_t dispatch_tags [2],
	input completion_t completions [2],
	input logic space_t1,
	input logic space_t2,
	input index_t tail_t1,
	input index_t tail_t2,
	input logic flush_t1,
	input logic flush_t2,
	output logic alloc_t1,
	output logic alloc_t2,
	output dispatch_slot_t alloc_slots [2],
	output completion_t mark_t1 [2],
	output completion_t mark_t2 [2]
);

	index_t tail;
	logic thread_open_t1;
	logic thread_open_t2;

	// a flushing thread takes no new pair this cycle
	assign thread_open_t1 = space_t1 && !flush_t1;
	assign thread_open_t2 = space_t2 && !flush_t2;

	assign tail = dispatch_thread1 ? tail_t1 : tail_t2;
	assign dispatch_ready = dispatch_thread1 ? thread_open_t1 : thread_open_t2;

	assign alloc_t1 = dispatch_valid && dispatch_thread1 && thread_open_t1;
	assign alloc_t2 = dispatch_valid && !dispatch_thread1 && thread_open_t2;

	// tags are known before the pair is written
	always_comb
	begin
		for (int k = 0; k < 2; k++)
		begin
			dispatch_tags[k].is_thread2 = !dispatch_thread1;
			dispatch_tags[k].index = index_t'(tail + k);
			alloc_slots[k] = (alloc_t1 || alloc_t2) ? dispatch_slots[k] : '0;
		end
	end

	// split each completion by its thread bit
	always_comb
	begin
		for (int k = 0; k < 2; k++)
		begin
			mark_t1[k] = completions[k];
			mark_t2[k] = completions[k];
			mark_t1[k].tag.is_thread2 = 1'b0;
			mark_t2[k].tag.is_thread2 = 1'b0;
			mark_t1[k].valid = completions[k].valid && !completions[k].tag.is_thread2;
			mark_t2[k].valid = completions[k].valid && completions[k].tag.is_thread2;
		end
	end

	// functional units never finish the same instruction twice in one cycle
	always_comb
	begin
		if (completions[0].valid && completions[1].valid)
		begin
			a_unique_completion: assert #0 (completions[0].tag != completions[1].tag)
				else $error("both completion ports carry tag %h", completions[0].tag);
		end
	end

endmodule

`default_nettype wire

// File: design/thread_rob.sv
// per-thread reorder queue
`timescale 1ns/1ps
`default_nettype none

module thread_rob import rob_pkg::*; (
	input logic clock,
	input logic reset,
	input logic alloc,
	input dispatch_slot_t alloc_slots [2],
	input completion_t marks [2],
	input logic [1:0] retire_count,
	input logic flush,
	output logic has_space,
	output index_t tail_index,
	output rob_entry_t head_entries [2],
	output ptr_t occupancy
);

	rob_entry_t entries [rob_depth];
	ptr_t head_ptr;
	ptr_t tail_ptr;
	ptr_t next_head;
	index_t head_index;
	logic [1:0] mark_ok;

	assign head_index = head_ptr[index_width-1:0];
	assign tail_index = tail_ptr[index_width-1:0];

	// wrap bit makes full and empty distinct
	assign occupancy = tail_ptr - head_ptr;
	assign has_space = occupancy <= ptr_t'(rob_depth - 2);	// room for a whole pair
	assign next_head = head_ptr + ptr_t'(retire_count);

	assign head_entries[0] = entries[head_index];
	assign head_entries[1] = entries[index_t'(head_index + 1'b1)];

	// completions for entries that were flushed away are ignored
	always_comb
	begin
		for (int k = 0; k < 2; k++)
		begin
			mark_ok[k] = marks[k].valid
				&& ptr_t'(index_t'(marks[k].tag.index - head_index)) < occupancy;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head_ptr <= '0;
			tail_ptr <= '0;
		end
		else
		begin
			head_ptr <= next_head;
			if (flush)
				tail_ptr <= next_head;	// younger entries are gone
			else if (alloc)
				tail_ptr <= tail_ptr + ptr_t'(2);
		end
	end

	always_ff @(posedge clock)
	begin
		if (alloc)
		begin
			for (int k = 0; k < 2; k++)
			begin
				entries[index_t'(tail_index + k)] <= '{
					slot: alloc_slots[k],
					executed: 1'b0,
					mispredict: 1'b0,
					target_pc: '0
				};
			end
		end
		for (int k = 0; k < 2; k++)
		begin
			if (mark_ok[k])
			begin
				entries[marks[k].tag.index].executed <= 1'b1;
				entries[marks[k].tag.index].mispredict <= marks[k].mispredict;
				entries[marks[k].tag.index].target_pc <= marks[k].target_pc;
			end
		end
	end

	// router must hold back a pair while the queue lacks room
	a_alloc_space: assert property (@(posedge clock) disable iff (reset)
		alloc |-> has_space)
		else $error("pair allocated into a full queue");

	// selector only retires entries that exist
	a_retire_bound: assert property (@(posedge clock) disable iff (reset)
		ptr_t'(retire_count) <= occupancy)
		else $error("retire count %0d above occupancy %0d", retire_count, occupancy);

endmodule

`default_nettype wire

// File: rob.f
design/rob_pkg.sv
design/tag_router.sv
design/thread_rob.sv
design/commit_select.sv
design/rob_top.sv
verification/rob_tb.sv

// File: verification/rob_tb.sv
// reorder buffer testbench
`timescale 1ns/1ps
`default_nettype none

module rob_tb import rob_pkg::*; ();

	localparam int timeout_cycles = 200;

	logic clock;
	logic reset;
	logic dispatch_valid;
	logic dispatch_thread1;
	dispatch_slot_t dispatch_slots [2];
	logic dispatch_ready;
	rob_tag_t dispatch_tags [2];
	completion_t completions [2];
	commit_slot_t commit_slots [2];

	commit_slot_t commit_queue [$];	// committed records in retire order
	index_t tags_t1 [$];	// tag index of every dispatched instruction, by thread
	index_t tags_t2 [$];
	dispatch_slot_t slots_t1 [$];	// dispatched payloads, same order as the tags
	dispatch_slot_t slots_t2 [$];
	logic [xlen-1:0] targets_t1 [$];	// target pc given by the last completion
	logic [xlen-1:0] targets_t2 [$];

	rob_top dut (
		.clock(clock),
		.reset(reset),
		.dispatch_valid(dispatch_valid),
		.dispatch_thread1(dispatch_thread1),
		.dispatch_slots(dispatch_slots),
		.dispatch_ready(dispatch_ready),
		.dispatch_tags(dispatch_tags),
		.completions(completions),
		.commit_slots(commit_slots)
	);

	always #50 clock = ~clock;

	// slot 1 is older than slot 2 within one cycle
	always @(negedge clock)
	begin
		if (!reset)
		begin
			for (int k = 0; k < 2; k++)
			begin
				if (commit_slots[k].valid)
					commit_queue.push_back(commit_slots[k]);
			end
		end
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
			fail_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic dispatch_pair(input int thread, input index_t first_index,
		input dispatch_slot_t slot_a, input dispatch_slot_t slot_b);
		int waited;
		waited = 0;
		@(posedge clock);
		dispatch_valid <= 1'b1;
		dispatch_thread1 <= (thread == 1);
		dispatch_slots[0] <= slot_a;
		dispatch_slots[1] <= slot_b;
		@(negedge clock);
		while (!dispatch_ready)
		begin
			waited++;
			if (waited > timeout_cycles)
				fail_run($sformatf("thread %0d never became ready for dispatch", thread));
			@(negedge clock);
		end
		check_value("dispatch_tags[0].is_thread2", thread == 2, dispatch_tags[0].is_thread2);
		check_value("dispatch_tags[1].is_thread2", thread == 2, dispatch_tags[1].is_thread2);
		check_value("dispatch_tags[0].index", first_index, dispatch_tags[0].index);
		check_value("dispatch_tags[1].index", index_t'(first_index + 1), dispatch_tags[1].index);
		for (int k = 0; k < 2; k++)
		begin
			if (thread == 1)
			begin
				tags_t1.push_back(index_t'(first_index + k));
				slots_t1.push_back(k == 0 ? slot_a : slot_b);
				targets_t1.push_back('0);
			end
			else
			begin
				tags_t2.push_back(index_t'(first_index + k));
				slots_t2.push_back(k == 0 ? slot_a : slot_b);
				targets_t2.push_back('0);
			end
		end
		@(posedge clock);	// transfer edge
		dispatch_valid <= 1'b0;
	endtask

	// thread 0 leaves the port idle
	task automatic build_completion(input int thread, input int offset, input logic mispredict,
		input logic [xlen-1:0] target, output completion_t result);
		result = '0;
		if (thread != 0)
		begin
			if (offset >= (thread == 1 ? tags_t1.size() : tags_t2.size()))
				fail_run($sformatf("completion offset %0d beyond thread %0d dispatches",
					offset, thread));
			result.valid = 1'b1;
			result.tag.is_thread2 = (thread == 2);
			result.tag.index = (thread == 1) ? tags_t1[offset] : tags_t2[offset];
			result.mispredict = mispredict;
			result.target_pc = target;
			if (thread == 1)
				targets_t1[offset] = target;
			else
				targets_t2[offset] = target;
		end
	endtask

	task automatic expect_commit(input logic is_thread1, input logic [xlen-1:0] pc,
		input logic mispredict);
		int waited;
		int found;
		commit_slot_t got;
		dispatch_slot_t sent;
		logic [xlen-1:0] target;
		waited = 0;
		found = -1;
		// the expected record is the one dispatched with this pc
		if (is_thread1)
		begin
			for (int k = 0; k < slots_t1.size(); k++)
			begin
				if (slots_t1[k].pc == pc)
					found = k;
			end
		end
		else
		begin
			for (int k = 0; k < slots_t2.size(); k++)
			begin
				if (slots_t2[k].pc == pc)
					found = k;
			end
		end
		if (found < 0)
			fail_run($sformatf("expected pc %h was never dispatched", pc));
		sent = is_thread1 ? slots_t1[found] : slots_t2[found];
		target = is_thread1 ? targets_t1[found] : targets_t2[found];
		while (commit_queue.size() == 0)
		begin
			waited++;
			if (waited > timeout_cycles)
				fail_run($sformatf("no commit arrived for expected pc %h", pc));
			@(posedge clock);
		end
		got = commit_queue.pop_front();
		check_value("commit_slots.is_thread1", is_thread1, got.is_thread1);
		check_value("commit_slots.pc", pc, got.pc);
		check_value("commit_slots.mispredict", mispredict, got.mispredict);
		check_value("commit_slots.target_pc", target, got.target_pc);
		check_value("commit_slots.is_branch", sent.is_branch, got.is_branch);
		check_value("commit_slots.arn", sent.arn, got.arn);
		check_value("commit_slots.prn", sent.prn, got.prn);
	endtask

	task automatic check_ready(input int thread, input logic expected);
		@(posedge clock);
		dispatch_valid <= 1'b0;
		dispatch_thread1 <= (thread == 1);
		@(negedge clock);
		check_value("dispatch_ready", expected, dispatch_ready);
	endtask

	initial
	begin
		int fd;
		int count;
		string line;
		string args;
		logic [63:0] f [10];
		dispatch_slot_t slot_a;
		dispatch_slot_t slot_b;
		completion_t comp_a;
		completion_t comp_b;
		clock = 1'b0;
		reset = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_thread1 = 1'b1;
		dispatch_slots[0] = '0;
		dispatch_slots[1] = '0;
		completions[0] = '0;
		completions[1] = '0;
		repeat (10) @(posedge clock);
		reset <= 1'b0;

		fd = $fopen("verification/rob_testdata.txt", "r");
		if (fd == 0)
			fail_run("could not open verification/rob_testdata.txt");
		while (!$feof(fd))
		begin
			count = $fgets(line, fd);
			if (count < 2 || line.getc(0) == "#")
				continue;
			args = line.substr(1, line.len() - 1);
			case (line.getc(0))
				"D":
				begin
					count = $sscanf(args, "%d %h %h %h %h %d %h %h %h %d", f[0], f[1], f[2],
						f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
					if (count != 10)
						fail_run($sformatf("malformed dispatch line: %s", line));
					slot_a.pc = f[2];
					slot_a.arn = f[3][arn_width-1:0];
					slot_a.prn = f[4][prn_width-1:0];
					slot_a.is_branch = f[5][0];
					slot_b.pc = f[6];
					slot_b.arn = f[7][arn_width-1:0];
					slot_b.prn = f[8][prn_width-1:0];
					slot_b.is_branch = f[9][0];
					dispatch_pair(f[0], f[1][index_width-1:0], slot_a, slot_b);
				end
				"C":
				begin
					count = $sscanf(args, "%d %d %d %h %d %d %d %h", f[0], f[1], f[2], f[3],
						f[4], f[5], f[6], f[7]);
					if (count != 8)
						fail_run($sformatf("malformed completion line: %s", line));
					build_completion(f[0], f[1], f[2][0], f[3], comp_a);
					build_completion(f[4], f[5], f[6][0], f[7], comp_b);
					@(posedge clock);
					completions[0] <= comp_a;
					completions[1] <= comp_b;
					@(posedge clock);	// applied at this edge
					completions[0] <= '0;
					completions[1] <= '0;
				end
				"I":
				begin
					count = $sscanf(args, "%d", f[0]);
					if (count != 1)
						fail_run($sformatf("malformed idle line: %s", line));
					repeat (f[0]) @(posedge clock);
				end
				"E":
				begin
					count = $sscanf(args, "%d %h %d", f[0], f[1], f[2]);
					if (count != 3)
						fail_run($sformatf("malformed expect line: %s", line));
					expect_commit(f[0][0], f[1], f[2][0]);
				end
				"R":
				begin
					count = $sscanf(args, "%d %d", f[0], f[1]);
					if (count != 2)
						fail_run($sformatf("malformed ready line: %s", line));
					check_ready(f[0], f[1][0]);
				end
				default:
					fail_run($sformatf("unknown command in test data: %s", line));
			endcase
		end
		$fclose(fd);

		// flushed entries must never show up
		if (commit_queue.size() != 0)
			fail_run($sformatf("%0d commits arrived beyond the expected ones",
				commit_queue.size()));
		else
		begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verification/rob_testdata.txt
# D thread first_index pc arn prn br pc arn prn br | E is_thread1 pc mispredict | I cycles
# C thread offset mispredict target (twice, thread 0 idle) | R thread ready | offsets decimal
D 1 0 100 1 20 0 104 2 21 0
C 1 1 0 0 0 0 0 0
I 2
C 1 0 0 0 0 0 0 0
E 1 100 0
E 1 104 0
D 1 2 200 3 22 0 204 4 23 0
D 2 0 300 5 24 0 304 6 25 0
C 1 2 0 0 2 0 0 0
E 1 200 0
E 0 300 0
C 1 3 0 0 2 1 0 0
E 1 204 0
E 0 304 0
D 1 4 400 1 30 0 404 2 31 0
D 1 6 408 3 32 1 40c 4 33 0
D 1 8 410 5 34 0 414 6 35 0
D 1 a 418 7 36 0 41c 8 37 0
D 1 c 420 9 38 0 424 a 39 0
D 1 e 428 b 3a 0 42c c 3b 0
D 1 0 430 d 3c 0 434 e 3d 0
D 1 2 438 f 3e 0 43c 10 3f 0
R 1 0
R 2 1
D 2 2 500 11 2a 0 504 12 2b 0
C 1 4 0 0 1 5 0 0
E 1 400 0
E 1 404 0
D 1 4 440 13 2c 0 444 14 2d 0
C 1 6 1 900 1 7 0 0
E 1 408 1
C 1 8 0 0 0 0 0 0
I 3
D 1 7 600 15 2e 0 604 16 2f 0
C 2 2 0 0 2 3 0 0
E 0 500 0
E 0 504 0
C 1 22 0 0 1 23 0 0
E 1 600 0
E 1 604 0
I 5
